//--- logic/sublane_pkg.sv
package sublane_pkg;

    ////////////////////////////////////////
    // Lane group geometry
    ////////////////////////////////////////
    localparam int LANE_NUM        = 8;
    localparam int MEM_DEPTH       = 512;                     // Locations per lane
    localparam int MAX_VL_PER_LANE = 256;
    localparam int RD_PORTS        = 2;                       // vs1 and vs2
    localparam int BWEN_W          = 4;                       // One enable per byte of a word

    localparam int ADDR_W  = $clog2(MEM_DEPTH);
    localparam int CNT_W   = $clog2(MAX_VL_PER_LANE);
    localparam int VL_W    = $clog2(LANE_NUM * MAX_VL_PER_LANE);
    localparam int LANE_SH = $clog2(LANE_NUM);               // vl to per-lane count

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////
    // Element width where zero is not legal
    typedef enum logic [1:0] {
        EW_BYTE = 2'd1,
        EW_HALF = 2'd2,
        EW_WORD = 2'd3
    } width_e;

    typedef enum logic [1:0] {
        IT_NORMAL,
        IT_STORE,
        IT_LOAD
    } inst_type_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_NORMAL,
        ST_STORE,
        ST_LOAD
    } state_e;

    // Everything the issuer hands over with the start strobe
    typedef struct packed {
        inst_type_e                       inst_type;
        logic [VL_W-1:0]                  vl;
        width_e                           sew;
        width_e                           wdata_width;
        logic [CNT_W-1:0]                 inst_delay;      // Read to write pipeline delay
        logic                             vector_mask;
        logic [ADDR_W-1:0]                waddr_start;
        logic [RD_PORTS-1:0][ADDR_W-1:0]  raddr_start;
    } inst_cfg_t;

    typedef logic [LANE_NUM-1:0][BWEN_W-1:0] lane_bwen_t;

endpackage

//--- logic/addr_counter.sv
module addr_counter (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           load_i,
    input  logic                           en_i,
    input  sublane_pkg::width_e            width_i,
    input  logic [sublane_pkg::ADDR_W-1:0] start_addr_i,
    output logic [sublane_pkg::ADDR_W-1:0] addr_o
);

    logic [1:0] sub_cnt;                    // Element slot inside the current word
    logic       step;

    // Move to the next word once its last element is consumed
    always_comb begin
        case (width_i)
            sublane_pkg::EW_BYTE: step = (sub_cnt == 2'd3);
            sublane_pkg::EW_HALF: step = sub_cnt[0];
            default:              step = 1'b1;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            addr_o  <= '0;
            sub_cnt <= '0;
        end else if (load_i) begin
            addr_o  <= start_addr_i;
            sub_cnt <= '0;
        end else if (en_i) begin
            sub_cnt <= sub_cnt + 2'd1;
            if (step) begin
                // Wrap at the end of the lane memory
                if (int'(addr_o) == sublane_pkg::MEM_DEPTH - 1) begin
                    addr_o <= '0;
                end else begin
                    addr_o <= addr_o + 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/byte_enable_gen.sv
module byte_enable_gen (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    wr_phase_i,
    input  sublane_pkg::width_e     width_i,
    input  logic                    load_mode_i,
    input  sublane_pkg::lane_bwen_t load_bwen_i,
    output sublane_pkg::lane_bwen_t bwen_o
);

    logic [3:0] rot4;                       // Byte slot, one-hot
    logic [1:0] rot2;                       // Halfword slot
    logic [3:0] pattern;

    ////////////////////////////////////////
    // Rotation state
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            rot4 <= 4'b0001;
            rot2 <= 2'b01;
        end else if (wr_phase_i) begin
            rot4 <= {rot4[2:0], rot4[3]};
            rot2 <= {rot2[0], rot2[1]};
        end else begin
            rot4 <= 4'b0001;                // Park on the first pattern
            rot2 <= 2'b01;
        end
    end

    always_comb begin
        case (width_i)
            sublane_pkg::EW_BYTE: pattern = rot4;
            sublane_pkg::EW_HALF: pattern = {{2{rot2[1]}}, {2{rot2[0]}}};
            sublane_pkg::EW_WORD: pattern = 4'b1111;
            default:              pattern = 4'b0000;
        endcase
    end

    // Same pattern on every lane unless the load unit drives the enables
    always_comb begin
        if (!wr_phase_i) begin
            bwen_o = '0;
        end else if (load_mode_i) begin
            bwen_o = load_bwen_i;
        end else begin
            bwen_o = {sublane_pkg::LANE_NUM{pattern}};
        end
    end

endmodule

//--- logic/lane_valid_gen.sv
module lane_valid_gen (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             load_i,
    input  logic                             en_i,
    input  logic [sublane_pkg::VL_W-1:0]     vl_i,
    output logic [sublane_pkg::LANE_NUM-1:0] valid_o
);

    logic [sublane_pkg::VL_W-1:0]     remain_q;     // Elements not yet covered by a beat
    logic [sublane_pkg::VL_W-1:0]     remain;
    logic [sublane_pkg::LANE_NUM-1:0] mask;

    // A fresh load counts from vl directly
    always_comb begin
        remain = load_i ? vl_i : remain_q;
        for (int l = 0; l < sublane_pkg::LANE_NUM; l++) begin
            mask[l] = (int'(remain) > l);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            remain_q <= '0;
            valid_o  <= '0;
        end else if (en_i) begin
            valid_o <= mask;
            if (int'(remain) > sublane_pkg::LANE_NUM) begin
                remain_q <= remain - sublane_pkg::VL_W'(sublane_pkg::LANE_NUM);
            end else begin
                remain_q <= '0;
            end
        end else begin
            valid_o <= '0;                  // Lanes drop between beats
            if (load_i) begin
                remain_q <= vl_i;
            end
        end
    end

endmodule

//--- logic/sublane_ctrl_fsm.sv
module sublane_ctrl_fsm (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          start_i,
    input  sublane_pkg::inst_cfg_t        cfg_i,
    input  logic                          load_last_i,
    output logic                          ready_o,
    output sublane_pkg::inst_cfg_t        cfg_o,
    output logic                          rd_load_o,
    output logic                          rd_en_o,
    output logic                          wr_load_o,
    output logic                          wr_en_o,
    output logic                          beat_load_o,
    output logic                          beat_en_o,
    output logic                          wr_phase_o,
    output logic                          load_mode_o,
    output sublane_pkg::width_e           rd_width_o,
    output sublane_pkg::width_e           wr_width_o,
    output logic [sublane_pkg::CNT_W-1:0] vmrf_addr_o,
    output logic                          vmrf_wen_o,
    output logic                          store_data_valid_o,
    output logic                          request_write_control_o
);

    sublane_pkg::state_e           state;
    sublane_pkg::state_e           state_next;
    logic                          accept;
    logic                          start_q;         // Config captured, mode starts next edge
    logic [sublane_pkg::VL_W-1:0]  vl_m1;
    logic [sublane_pkg::CNT_W-1:0] n_m1;            // Per-lane elements minus one
    logic [sublane_pkg::CNT_W:0]   main_cnt;        // Cycles since the first read beat
    logic [sublane_pkg::CNT_W:0]   wr_first;
    logic [sublane_pkg::CNT_W:0]   wr_last;
    logic                          reading;
    logic                          normal_wr;
    logic                          rd_typed;

    assign accept = start_i && ready_o;
    assign vl_m1  = cfg_i.vl - 1'b1;

    ////////////////////////////////////////
    // Instruction register
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            cfg_o   <= '0;
            n_m1    <= '0;
            start_q <= 1'b0;
        end else begin
            start_q <= accept;
            if (accept) begin
                cfg_o <= cfg_i;
                n_m1  <= vl_m1[sublane_pkg::LANE_SH +: sublane_pkg::CNT_W];   // ceil(vl/8)-1
            end
        end
    end

    // Read and write windows in main counter cycles
    assign wr_first  = {1'b0, cfg_o.inst_delay};
    assign wr_last   = wr_first + {1'b0, n_m1};
    assign reading   = (state == sublane_pkg::ST_STORE)
                    || (state == sublane_pkg::ST_NORMAL && main_cnt <= {1'b0, n_m1});
    assign normal_wr = (state == sublane_pkg::ST_NORMAL)
                    && (main_cnt >= wr_first) && (main_cnt <= wr_last);
    assign rd_typed  = (cfg_o.inst_type == sublane_pkg::IT_NORMAL)
                    || (cfg_o.inst_type == sublane_pkg::IT_STORE);

    ////////////////////////////////////////
    // Main and mask counters
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            main_cnt    <= '0;
            vmrf_addr_o <= '0;
        end else begin
            if (state == sublane_pkg::ST_IDLE) begin
                main_cnt <= '0;
            end else if (state != sublane_pkg::ST_LOAD) begin
                main_cnt <= main_cnt + 1'b1;
            end
            if (start_q) begin
                vmrf_addr_o <= '0;
            end else if (normal_wr) begin
                vmrf_addr_o <= vmrf_addr_o + 1'b1;  // One mask entry per written element
            end
        end
    end

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state   <= sublane_pkg::ST_IDLE;
            ready_o <= 1'b1;
        end else begin
            state <= state_next;
            if (accept) begin
                ready_o <= 1'b0;
            end else if (state == sublane_pkg::ST_IDLE && !start_q) begin
                ready_o <= 1'b1;                    // One cycle after returning to idle
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            sublane_pkg::ST_IDLE: begin
                if (start_q) begin
                    case (cfg_o.inst_type)
                        sublane_pkg::IT_NORMAL: state_next = sublane_pkg::ST_NORMAL;
                        sublane_pkg::IT_STORE:  state_next = sublane_pkg::ST_STORE;
                        sublane_pkg::IT_LOAD:   state_next = sublane_pkg::ST_LOAD;
                        default:                state_next = sublane_pkg::ST_IDLE;
                    endcase
                end
            end
            sublane_pkg::ST_NORMAL: begin
                if (main_cnt == wr_last) begin      // Write window always ends last
                    state_next = sublane_pkg::ST_IDLE;
                end
            end
            sublane_pkg::ST_STORE: begin
                if (main_cnt == {1'b0, n_m1}) begin
                    state_next = sublane_pkg::ST_IDLE;
                end
            end
            sublane_pkg::ST_LOAD: begin
                if (load_last_i) begin
                    state_next = sublane_pkg::ST_IDLE;
                end
            end
            default: state_next = sublane_pkg::ST_IDLE;
        endcase
    end

    ////////////////////////////////////////
    // Datapath controls
    ////////////////////////////////////////
    assign rd_load_o   = start_q;
    assign wr_load_o   = start_q;
    assign beat_load_o = start_q;
    assign rd_en_o     = reading;

    // Valid mask is registered, so each beat is prepared a cycle ahead
    assign beat_en_o = (start_q && rd_typed) || (reading && main_cnt < {1'b0, n_m1});

    assign load_mode_o = (state == sublane_pkg::ST_LOAD);
    assign wr_phase_o  = normal_wr || load_mode_o;
    assign wr_en_o     = wr_phase_o;

    assign rd_width_o = (cfg_o.inst_type == sublane_pkg::IT_STORE) ? sublane_pkg::EW_WORD
                                                                    : cfg_o.sew;
    assign wr_width_o = (cfg_o.inst_type == sublane_pkg::IT_LOAD) ? sublane_pkg::EW_WORD
                                                                   : cfg_o.wdata_width;

    assign vmrf_wen_o              = normal_wr && cfg_o.vector_mask;
    assign store_data_valid_o      = (state == sublane_pkg::ST_STORE);
    assign request_write_control_o = load_mode_o;

endmodule

//--- logic/sublane_driver.sv
module sublane_driver (
    input  logic                                                 clk_i,
    input  logic                                                 rst_i,
    input  logic                                                 start_i,
    input  sublane_pkg::inst_cfg_t                               cfg_i,
    input  logic                                                 load_last_i,
    input  sublane_pkg::lane_bwen_t                              load_bwen_i,
    output logic                                                 ready_o,
    output logic [sublane_pkg::RD_PORTS-1:0][sublane_pkg::ADDR_W-1:0] vrf_raddr_o,
    output logic [sublane_pkg::ADDR_W-1:0]                       vrf_waddr_o,
    output sublane_pkg::lane_bwen_t                              vrf_bwen_o,
    output logic [sublane_pkg::LANE_NUM-1:0]                     read_data_valid_o,
    output logic [sublane_pkg::CNT_W-1:0]                        vmrf_addr_o,
    output logic                                                 vmrf_wen_o,
    output logic                                                 store_data_valid_o,
    output logic                                                 request_write_control_o,
    output sublane_pkg::width_e                                  vsew_o
);

    sublane_pkg::inst_cfg_t cfg_q;
    sublane_pkg::width_e    rd_width;
    sublane_pkg::width_e    wr_width;
    logic                   rd_load;
    logic                   rd_en;
    logic                   wr_load;
    logic                   wr_en;
    logic                   beat_load;
    logic                   beat_en;
    logic                   wr_phase;
    logic                   load_mode;

    assign vsew_o = cfg_q.sew;

    sublane_ctrl_fsm sublane_ctrl_fsm_inst (
        .clk_i                   (clk_i),
        .rst_i                   (rst_i),
        .start_i                 (start_i),
        .cfg_i                   (cfg_i),
        .load_last_i             (load_last_i),
        .ready_o                 (ready_o),
        .cfg_o                   (cfg_q),
        .rd_load_o               (rd_load),
        .rd_en_o                 (rd_en),
        .wr_load_o               (wr_load),
        .wr_en_o                 (wr_en),
        .beat_load_o             (beat_load),
        .beat_en_o               (beat_en),
        .wr_phase_o              (wr_phase),
        .load_mode_o             (load_mode),
        .rd_width_o              (rd_width),
        .wr_width_o              (wr_width),
        .vmrf_addr_o             (vmrf_addr_o),
        .vmrf_wen_o              (vmrf_wen_o),
        .store_data_valid_o      (store_data_valid_o),
        .request_write_control_o (request_write_control_o)
    );

    ////////////////////////////////////////
    // Address counters
    ////////////////////////////////////////
    for (genvar p = 0; p < sublane_pkg::RD_PORTS; p++) begin : g_raddr
        addr_counter raddr_cnt_inst (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .load_i       (rd_load),
            .en_i         (rd_en),
            .width_i      (rd_width),
            .start_addr_i (cfg_q.raddr_start[p]),
            .addr_o       (vrf_raddr_o[p])
        );
    end

    addr_counter waddr_cnt_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .load_i       (wr_load),
        .en_i         (wr_en),
        .width_i      (wr_width),
        .start_addr_i (cfg_q.waddr_start),
        .addr_o       (vrf_waddr_o)
    );

    byte_enable_gen byte_enable_gen_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .wr_phase_i  (wr_phase),
        .width_i     (wr_width),
        .load_mode_i (load_mode),
        .load_bwen_i (load_bwen_i),
        .bwen_o      (vrf_bwen_o)
    );

    lane_valid_gen lane_valid_gen_inst (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .load_i  (beat_load),
        .en_i    (beat_en),
        .vl_i    (cfg_q.vl),
        .valid_o (read_data_valid_o)
    );

endmodule

//--- tb/sublane_driver_checker.sv
module sublane_driver_checker (
    input logic                    clk_i,
    input logic                    rst_i,
    input logic                    start_i,
    input logic                    ready_i,
    input logic                    vmrf_wen_i,
    input sublane_pkg::lane_bwen_t bwen_i,
    input logic                    store_valid_i,
    input logic                    write_req_i
);
    timeunit 1ns;
    timeprecision 1ps;

    ////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////
    // Issuer strobes only while the controller is idle
    start_while_ready: assert property (@(posedge clk_i) disable iff (!rst_i)
        start_i |-> ready_i)
        else $error("start_i raised while ready_o was low");

    ////////////////////////////////////////
    // Mutual exclusion
    ////////////////////////////////////////
    mask_write_has_bytes: assert property (@(posedge clk_i) disable iff (!rst_i)
        vmrf_wen_i |-> (bwen_i != '0))
        else $error("vmrf_wen_o high with all byte enables low");

    store_or_load: assert property (@(posedge clk_i) disable iff (!rst_i)
        !(store_valid_i && write_req_i))
        else $error("store data valid and load write request high together");

endmodule

//--- tb/sublane_driver_tb.sv
module sublane_driver_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 20;
    localparam int N_NORMAL    = 40;
    localparam int N_STORE     = 20;
    localparam int N_LOAD      = 20;
    localparam int VL_MAX      = 600;
    localparam int DELAY_MAX   = 31;
    localparam int LOAD_MAX    = 40;
    localparam int N_MAX       = (VL_MAX + sublane_pkg::LANE_NUM - 1) / sublane_pkg::LANE_NUM;
    localparam int OVERHEAD    = 8;                 // Strobe, config cycle, two idle cycles
    localparam int CYCLE_LIMIT = 10 + N_NORMAL * (N_MAX + DELAY_MAX + OVERHEAD)
                               + N_STORE * (N_MAX + OVERHEAD)
                               + N_LOAD * (LOAD_MAX + OVERHEAD) + 200;

    logic                                                         clk_i;
    logic                                                         rst_i;
    logic                                                         start_i;
    sublane_pkg::inst_cfg_t                                       cfg_i;
    logic                                                         load_last_i;
    sublane_pkg::lane_bwen_t                                      load_bwen_i;
    logic                                                         ready_o;
    logic [sublane_pkg::RD_PORTS-1:0][sublane_pkg::ADDR_W-1:0]    vrf_raddr_o;
    logic [sublane_pkg::ADDR_W-1:0]                               vrf_waddr_o;
    sublane_pkg::lane_bwen_t                                      vrf_bwen_o;
    logic [sublane_pkg::LANE_NUM-1:0]                             read_data_valid_o;
    logic [sublane_pkg::CNT_W-1:0]                                vmrf_addr_o;
    logic                                                         vmrf_wen_o;
    logic                                                         store_data_valid_o;
    logic                                                         request_write_control_o;
    sublane_pkg::width_e                                          vsew_o;

    integer seed;
    int     cycles = 0;
    int     errors = 0;
    int     checks = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    int     test_errs = 0;

    sublane_driver sublane_driver_inst (
        .clk_i                   (clk_i),
        .rst_i                   (rst_i),
        .start_i                 (start_i),
        .cfg_i                   (cfg_i),
        .load_last_i             (load_last_i),
        .load_bwen_i             (load_bwen_i),
        .ready_o                 (ready_o),
        .vrf_raddr_o             (vrf_raddr_o),
        .vrf_waddr_o             (vrf_waddr_o),
        .vrf_bwen_o              (vrf_bwen_o),
        .read_data_valid_o       (read_data_valid_o),
        .vmrf_addr_o             (vmrf_addr_o),
        .vmrf_wen_o              (vmrf_wen_o),
        .store_data_valid_o      (store_data_valid_o),
        .request_write_control_o (request_write_control_o),
        .vsew_o                  (vsew_o)
    );

    bind sublane_driver sublane_driver_checker sublane_driver_checker_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .start_i       (start_i),
        .ready_i       (ready_o),
        .vmrf_wen_i    (vmrf_wen_o),
        .bwen_i        (vrf_bwen_o),
        .store_valid_i (store_data_valid_o),
        .write_req_i   (request_write_control_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Run limit
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////
    function automatic int per_word(input sublane_pkg::width_e w);
        case (w)
            sublane_pkg::EW_BYTE: return 4;
            sublane_pkg::EW_HALF: return 2;
            default:              return 1;
        endcase
    endfunction

    // Address after cnt enabled cycles
    function automatic logic [31:0] word_addr(input int start, input int cnt,
                                              input sublane_pkg::width_e w);
        return (start + cnt / per_word(w)) % sublane_pkg::MEM_DEPTH;
    endfunction

    function automatic logic [31:0] lane_mask(input int vl, input int beat);
        logic [31:0] m;
        m = '0;
        for (int l = 0; l < sublane_pkg::LANE_NUM; l++) begin
            if (beat * sublane_pkg::LANE_NUM + l < vl) begin
                m[l] = 1'b1;
            end
        end
        return m;
    endfunction

    function automatic logic [31:0] write_pattern(input sublane_pkg::width_e w, input int j);
        logic [3:0] p;
        case (w)
            sublane_pkg::EW_BYTE: p = 4'b0001 << (j % 4);
            sublane_pkg::EW_HALF: p = (j % 2 == 0) ? 4'b0011 : 4'b1100;
            default:              p = 4'b1111;
        endcase
        return {sublane_pkg::LANE_NUM{p}};
    endfunction

    function automatic int clamp(input int v, input int lo, input int hi);
        if (v < lo) begin
            return lo;
        end
        return (v > hi) ? hi : v;
    endfunction

    ////////////////////////////////////////
    // Stimulus and checking helpers
    ////////////////////////////////////////
    // Next falling edge, new inputs, then settle before sampling
    task automatic advance(input logic last);
        @(negedge clk_i);
        start_i     = 1'b0;
        load_last_i = last;
        load_bwen_i = sublane_pkg::lane_bwen_t'($random(seed));
        #(CLK_PERIOD / 4);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
            test_errs++;
        end
    endtask

    task automatic check_quiet(input logic exp_ready);
        check("ready_o", ready_o, exp_ready);
        check("read_data_valid_o", read_data_valid_o, 0);
        check("vrf_bwen_o", vrf_bwen_o, 0);
        check("vmrf_wen_o", vmrf_wen_o, 0);
        check("store_data_valid_o", store_data_valid_o, 0);
        check("request_write_control_o", request_write_control_o, 0);
    endtask

    task automatic random_cfg(input sublane_pkg::inst_type_e it,
                              output sublane_pkg::inst_cfg_t cfg);
        cfg.inst_type   = it;
        cfg.vl          = sublane_pkg::VL_W'(1 + {$random(seed)} % VL_MAX);
        cfg.sew         = sublane_pkg::width_e'(1 + {$random(seed)} % 3);
        cfg.wdata_width = sublane_pkg::width_e'(1 + {$random(seed)} % 3);
        cfg.inst_delay  = sublane_pkg::CNT_W'({$random(seed)} % (DELAY_MAX + 1));
        cfg.vector_mask = 1'($random(seed));
        cfg.waddr_start = sublane_pkg::ADDR_W'($random(seed));
        for (int p = 0; p < sublane_pkg::RD_PORTS; p++) begin
            cfg.raddr_start[p] = sublane_pkg::ADDR_W'($random(seed));
        end
    endtask

    // Strobe once ready, then check the config capture cycle
    task automatic issue(input sublane_pkg::inst_cfg_t cfg);
        @(negedge clk_i);
        while (!ready_o) begin
            @(negedge clk_i);
        end
        start_i     = 1'b1;
        cfg_i       = cfg;
        load_last_i = 1'b0;
        advance(1'b0);
        check_quiet(1'b0);
    endtask

    // Ready rises one cycle after the return to idle
    task automatic finish_instruction();
        advance(1'b0);
        check_quiet(1'b0);
        advance(1'b0);
        check_quiet(1'b1);
    endtask

    task automatic report(input string kind, input int idx, input int len);
        tests_run++;
        if (test_errs == 0) begin
            $display("%s test %0d (length %0d): ok", kind, idx, len);
        end else begin
            tests_failed++;
            $display("%s test %0d (length %0d): %0d mismatches", kind, idx, len, test_errs);
        end
        test_errs = 0;
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic run_normal(input int idx);
        sublane_pkg::inst_cfg_t cfg;
        int n;
        int d;
        int rcnt;
        int wcnt;
        random_cfg(sublane_pkg::IT_NORMAL, cfg);
        n = (int'(cfg.vl) + sublane_pkg::LANE_NUM - 1) / sublane_pkg::LANE_NUM;
        d = int'(cfg.inst_delay);
        issue(cfg);
        for (int t = 0; t < d + n; t++) begin
            advance(1'b0);
            rcnt = clamp(t, 0, n);
            wcnt = clamp(t - d, 0, n);
            for (int p = 0; p < sublane_pkg::RD_PORTS; p++) begin
                check($sformatf("vrf_raddr_o[%0d]", p), vrf_raddr_o[p],
                      word_addr(int'(cfg.raddr_start[p]), rcnt, cfg.sew));
            end
            check("read_data_valid_o", read_data_valid_o,
                  (t < n) ? lane_mask(int'(cfg.vl), t) : 32'd0);
            check("vrf_waddr_o", vrf_waddr_o,
                  word_addr(int'(cfg.waddr_start), wcnt, cfg.wdata_width));
            check("vmrf_addr_o", vmrf_addr_o, wcnt);
            if (t >= d) begin
                check("vrf_bwen_o", vrf_bwen_o, write_pattern(cfg.wdata_width, t - d));
                check("vmrf_wen_o", vmrf_wen_o, cfg.vector_mask);
            end else begin
                check("vrf_bwen_o", vrf_bwen_o, 0);
                check("vmrf_wen_o", vmrf_wen_o, 0);
            end
            check("store_data_valid_o", store_data_valid_o, 0);
            check("request_write_control_o", request_write_control_o, 0);
            check("ready_o", ready_o, 0);
            check("vsew_o", vsew_o, cfg.sew);
        end
        finish_instruction();
        report("normal", idx, n);
    endtask

    task automatic run_store(input int idx);
        sublane_pkg::inst_cfg_t cfg;
        int n;
        random_cfg(sublane_pkg::IT_STORE, cfg);
        n = (int'(cfg.vl) + sublane_pkg::LANE_NUM - 1) / sublane_pkg::LANE_NUM;
        issue(cfg);
        for (int t = 0; t < n; t++) begin
            advance(1'b0);
            for (int p = 0; p < sublane_pkg::RD_PORTS; p++) begin
                check($sformatf("vrf_raddr_o[%0d]", p), vrf_raddr_o[p],
                      word_addr(int'(cfg.raddr_start[p]), t, sublane_pkg::EW_WORD));
            end
            check("read_data_valid_o", read_data_valid_o, lane_mask(int'(cfg.vl), t));
            check("store_data_valid_o", store_data_valid_o, 1);
            check("request_write_control_o", request_write_control_o, 0);
            check("vrf_bwen_o", vrf_bwen_o, 0);
            check("vmrf_wen_o", vmrf_wen_o, 0);
            check("vrf_waddr_o", vrf_waddr_o, cfg.waddr_start);
            check("ready_o", ready_o, 0);
        end
        finish_instruction();
        report("store", idx, n);
    endtask

    task automatic run_load(input int idx);
        sublane_pkg::inst_cfg_t cfg;
        int m;
        random_cfg(sublane_pkg::IT_LOAD, cfg);
        m = 1 + {$random(seed)} % LOAD_MAX;
        issue(cfg);
        for (int t = 0; t < m; t++) begin
            advance(t == m - 1);
            check("request_write_control_o", request_write_control_o, 1);
            check("vrf_bwen_o", vrf_bwen_o, load_bwen_i);
            check("vrf_waddr_o", vrf_waddr_o,
                  word_addr(int'(cfg.waddr_start), t, sublane_pkg::EW_WORD));
            check("store_data_valid_o", store_data_valid_o, 0);
            check("read_data_valid_o", read_data_valid_o, 0);
            check("vmrf_wen_o", vmrf_wen_o, 0);
            check("ready_o", ready_o, 0);
        end
        finish_instruction();
        report("load", idx, m);
    endtask

    initial begin
        seed        = 32'he69eab9f;
        rst_i       = 1'b0;
        start_i     = 1'b0;
        cfg_i       = '0;
        load_last_i = 1'b0;
        load_bwen_i = '0;
        repeat (3) @(negedge clk_i);
        rst_i = 1'b1;

        #(CLK_PERIOD / 4);
        check_quiet(1'b1);                  // Idle state straight out of reset
        report("reset", 0, 0);

        for (int i = 0; i < N_NORMAL; i++) begin
            run_normal(i);
        end
        for (int i = 0; i < N_STORE; i++) begin
            run_store(i);
        end
        for (int i = 0; i < N_LOAD; i++) begin
            run_load(i);
        end

        $display("Tests run: %0d, failed: %0d, checks: %0d, mismatches: %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
logic/sublane_pkg.sv
logic/addr_counter.sv
logic/byte_enable_gen.sv
logic/lane_valid_gen.sv
logic/sublane_ctrl_fsm.sv
logic/sublane_driver.sv
tb/sublane_driver_checker.sv
tb/sublane_driver_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -Wno-fatal
TOP       = sublane_driver_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
